// ==== source/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define NUM_SRC     2

// opcodes of the supported RV32I subset
`define OP_R        7'b0110011
`define OP_IMM      7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111

`define FUNCT7_ALT  7'b0100000 // sub / sra

`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define LS_NONE     3'b111 // no load / no store

`endif

// ==== source/decodePkg.sv ====
`default_nettype none

`include "decode_defines.svh"

package decodePkg;

    typedef enum logic [2:0] {
        CLS_R,
        CLS_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_NOP
    } instrClass_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } aluOp_e;

    // state of the EX and MEM stages seen from decode
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] exRd;
        logic                   exRegWe;
        logic [`REG_ADDR_W-1:0] memRd;
        logic                   memRegWe;
        logic                   memIsLoad;
        logic [`XLEN-1:0]       memWbData;
    } hazInfo_t;

endpackage

`default_nettype wire

// ==== source/srcPortIf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

interface srcPortIf;

    logic [`REG_ADDR_W-1:0] addr;   // x0 when the source is unused
    logic                   used;
    logic [`XLEN-1:0]       rfData; // raw register file read
    logic [`XLEN-1:0]       value;  // after forwarding
    logic                   hazard;

    modport dec  (output addr, output used);
    modport rf   (input addr, output rfData);
    modport opnd (input addr, input rfData, output value, output hazard);
    modport iss  (input used, input value, input hazard);

endinterface

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module instrDecoder import decodePkg::*; (
    input  wire logic [`XLEN-1:0]       instr_i,
    srcPortIf.dec                       srcs [`NUM_SRC],
    output instrClass_e                 class_o,
    output aluOp_e                      aluOp_o,
    output logic [2:0]                  funct3_o,
    output logic [`REG_ADDR_W-1:0]      rd_o,
    output logic [`XLEN-1:0]            imm_o
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             altBit;
    logic [`XLEN-1:0] immI, immS, immB, immJ;
    aluOp_e           arithOp;
    logic             isR;
    logic             rs1Used, rs2Used;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign altBit   = instr_i[31:25] == `FUNCT7_ALT;
    assign isR      = opcode == `OP_R;

    assign funct3_o = funct3;
    assign rd_o     = instr_i[11:7];

    // ------------------------------------------------------------------
    // immediate formats
    // ------------------------------------------------------------------
    assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
    assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign immB = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign immJ = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        arithOp = ALU_NOP;
        case (funct3)
            `F3_ADD:  arithOp = (isR && altBit) ? ALU_SUB : ALU_ADD; // addi has no sub
            `F3_SLL:  arithOp = ALU_SLL;
            `F3_SLT:  arithOp = ALU_SLT;
            `F3_SLTU: arithOp = ALU_SLTU;
            `F3_XOR:  arithOp = ALU_XOR;
            `F3_SR:   arithOp = altBit ? ALU_SRA : ALU_SRL;
            `F3_OR:   arithOp = ALU_OR;
            `F3_AND:  arithOp = ALU_AND;
            default:  arithOp = ALU_NOP;
        endcase
    end

    // ------------------------------------------------------------------
    // classification
    // ------------------------------------------------------------------
    always_comb begin
        class_o = CLS_NOP;
        aluOp_o = ALU_NOP;
        imm_o   = '0;
        rs1Used = 1'b0;
        rs2Used = 1'b0;
        case (opcode)
            `OP_R: begin
                class_o = CLS_R;
                aluOp_o = arithOp;
                rs1Used = 1'b1;
                rs2Used = 1'b1;
            end
            `OP_IMM: begin
                class_o = CLS_IMM;
                aluOp_o = arithOp;
                imm_o   = immI;
                rs1Used = 1'b1;
            end
            `OP_LOAD: begin
                class_o = CLS_LOAD;
                aluOp_o = ALU_ADD; // address rs1 + imm
                imm_o   = immI;
                rs1Used = 1'b1;
            end
            `OP_STORE: begin
                class_o = CLS_STORE;
                aluOp_o = ALU_ADD;
                imm_o   = immS;
                rs1Used = 1'b1;
                rs2Used = 1'b1;
            end
            `OP_BRANCH: begin
                class_o = CLS_BRANCH; // resolved here, no alu work
                imm_o   = immB;
                rs1Used = 1'b1;
                rs2Used = 1'b1;
            end
            `OP_JAL: begin
                class_o = CLS_JAL;
                aluOp_o = ALU_ADD; // link value pc + 4
                imm_o   = immJ;
            end
            `OP_JALR: begin
                class_o = CLS_JALR;
                aluOp_o = ALU_ADD;
                imm_o   = immI;
                rs1Used = 1'b1;
            end
            default: begin
                class_o = CLS_NOP; // all-zero and unknown words
            end
        endcase
    end

    assign srcs[0].used = rs1Used;
    assign srcs[0].addr = rs1Used ? instr_i[19:15] : '0;
    assign srcs[1].used = rs2Used;
    assign srcs[1].addr = rs2Used ? instr_i[24:20] : '0;

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module regFile (
    input  wire logic                   clk,
    input  wire logic                   arstN_i,
    input  wire logic                   we_i,
    input  wire logic [`REG_ADDR_W-1:0] wrAddr_i,
    input  wire logic [`XLEN-1:0]       wrData_i,
    srcPortIf.rf                        rd [`NUM_SRC]
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wrAddr_i != '0) begin // x0 stays zero
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // read ports with write-through
    for (genvar gPort = 0; gPort < `NUM_SRC; gPort++) begin : readGen
        always_comb begin
            if (rd[gPort].addr == '0) begin
                rd[gPort].rfData = '0;
            end else if (we_i && wrAddr_i == rd[gPort].addr) begin
                rd[gPort].rfData = wrData_i;
            end else begin
                rd[gPort].rfData = regs[rd[gPort].addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/srcOperand.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module srcOperand import decodePkg::*; (
    srcPortIf.opnd          src,
    input  wire hazInfo_t   haz_i
);

    logic nonZero;
    logic exHit;
    logic memHit;

    assign nonZero = src.addr != '0; // x0 never matches
    assign exHit   = nonZero && haz_i.exRegWe  && (haz_i.exRd  == src.addr);
    assign memHit  = nonZero && haz_i.memRegWe && (haz_i.memRd == src.addr);

    // ------------------------------------------------------------------
    // forwarding from MEM
    // ------------------------------------------------------------------
    // a load in MEM has no data yet, so only non-load results forward
    assign src.value = (memHit && !haz_i.memIsLoad) ? haz_i.memWbData : src.rfData;

    // ------------------------------------------------------------------
    // hazard
    // ------------------------------------------------------------------
    // EX result not computed yet, or load data not back yet
    assign src.hazard = exHit || (memHit && haz_i.memIsLoad);

endmodule

`default_nettype wire

// ==== source/issueStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module issueStage import decodePkg::*; (
    input  wire logic                   clk,
    input  wire logic                   arstN_i,
    input  wire logic                   inValid_i,
    output logic                        inReady_o,
    input  wire logic [`XLEN-1:0]       pc_i,
    input  wire instrClass_e            class_i,
    input  wire aluOp_e                 aluOp_i,
    input  wire logic [2:0]             funct3_i,
    input  wire logic [`REG_ADDR_W-1:0] rd_i,
    input  wire logic [`XLEN-1:0]       imm_i,
    srcPortIf.iss                       srcs [`NUM_SRC],
    input  wire logic                   outReady_i,
    output logic                        outValid_o,
    output aluOp_e                      outAluOp_o,
    output logic [`XLEN-1:0]            outSrc1_o,
    output logic [`XLEN-1:0]            outSrc2_o,
    output logic [`REG_ADDR_W-1:0]      outRd_o,
    output logic                        outRegWe_o,
    output logic [2:0]                  outLoadCtl_o,
    output logic [2:0]                  outStoreCtl_o,
    output logic [`XLEN-1:0]            outStoreData_o,
    output logic                        outTaken_o,
    output logic [`XLEN-1:0]            outTarget_o
);

    logic [`XLEN-1:0] rs1, rs2;
    logic             brCond;
    logic             taken;
    logic [`XLEN-1:0] jalrSum;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] src1, src2;
    logic             writesRd;
    logic             isCtl;
    logic             srcHaz;
    logic             stall;
    logic             accept;

    assign rs1 = srcs[0].value;
    assign rs2 = srcs[1].value;

    // ------------------------------------------------------------------
    // branch and jump resolution
    // ------------------------------------------------------------------
    always_comb begin
        case (funct3_i)
            `F3_BEQ:  brCond = rs1 == rs2;
            `F3_BNE:  brCond = rs1 != rs2;
            `F3_BLT:  brCond = $signed(rs1) < $signed(rs2);
            `F3_BGE:  brCond = $signed(rs1) >= $signed(rs2);
            `F3_BLTU: brCond = rs1 < rs2;
            `F3_BGEU: brCond = rs1 >= rs2;
            default:  brCond = 1'b0;
        endcase
    end

    assign taken   = (class_i == CLS_BRANCH && brCond) || class_i == CLS_JAL
                     || class_i == CLS_JALR;
    assign jalrSum = rs1 + imm_i;
    assign target  = !taken ? '0
                   : (class_i == CLS_JALR) ? {jalrSum[`XLEN-1:1], 1'b0}
                   : pc_i + imm_i;

    // ------------------------------------------------------------------
    // operands
    // ------------------------------------------------------------------
    always_comb begin
        case (class_i)
            CLS_JAL, CLS_JALR: begin
                src1 = pc_i;
                src2 = `XLEN'd4;
            end
            CLS_IMM, CLS_LOAD, CLS_STORE: begin
                src1 = rs1;
                src2 = imm_i;
            end
            CLS_R: begin
                src1 = rs1;
                src2 = rs2;
            end
            default: begin
                src1 = '0;
                src2 = '0;
            end
        endcase
    end

    assign writesRd = class_i inside {CLS_R, CLS_IMM, CLS_LOAD, CLS_JAL, CLS_JALR};

    // ------------------------------------------------------------------
    // stall and handshake
    // ------------------------------------------------------------------
    assign isCtl     = class_i == CLS_BRANCH || class_i == CLS_JALR;
    assign srcHaz    = (srcs[0].used && srcs[0].hazard) || (srcs[1].used && srcs[1].hazard);
    assign stall     = inValid_i && isCtl && srcHaz; // compare needs a value not ready yet
    assign inReady_o = !stall && (!outValid_o || outReady_i);
    assign accept    = inValid_i && inReady_o;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            outValid_o     <= 1'b0;
            outAluOp_o     <= ALU_NOP;
            outSrc1_o      <= '0;
            outSrc2_o      <= '0;
            outRd_o        <= '0;
            outRegWe_o     <= 1'b0;
            outLoadCtl_o   <= '0;
            outStoreCtl_o  <= '0;
            outStoreData_o <= '0;
            outTaken_o     <= 1'b0;
            outTarget_o    <= '0;
        end else if (accept) begin
            outValid_o     <= 1'b1;
            outAluOp_o     <= aluOp_i;
            outSrc1_o      <= src1;
            outSrc2_o      <= src2;
            outRd_o        <= writesRd ? rd_i : '0;
            outRegWe_o     <= writesRd && rd_i != '0;
            outLoadCtl_o   <= (class_i == CLS_LOAD) ? funct3_i : `LS_NONE;
            outStoreCtl_o  <= (class_i == CLS_STORE) ? funct3_i : `LS_NONE;
            outStoreData_o <= (class_i == CLS_STORE) ? rs2 : '0;
            outTaken_o     <= taken;
            outTarget_o    <= target;
        end else if (outReady_i) begin
            outValid_o     <= 1'b0; // drained, bundle kept
        end
    end

endmodule

`default_nettype wire

// ==== source/decodeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decodeTop import decodePkg::*; (
    input  wire logic                   clk,
    input  wire logic                   arstN_i,
    // instruction in
    input  wire logic                   inValid_i,
    output logic                        inReady_o,
    input  wire logic [`XLEN-1:0]       inInstr_i,
    input  wire logic [`XLEN-1:0]       inPc_i,
    // write-back
    input  wire logic                   wbWe_i,
    input  wire logic [`REG_ADDR_W-1:0] wbRd_i,
    input  wire logic [`XLEN-1:0]       wbData_i,
    // EX / MEM state
    input  wire logic [`REG_ADDR_W-1:0] exRd_i,
    input  wire logic                   exRegWe_i,
    input  wire logic [`REG_ADDR_W-1:0] memRd_i,
    input  wire logic                   memRegWe_i,
    input  wire logic                   memIsLoad_i,
    input  wire logic [`XLEN-1:0]       memWbData_i,
    // issue bundle
    output logic                        outValid_o,
    input  wire logic                   outReady_i,
    output aluOp_e                      outAluOp_o,
    output logic [`XLEN-1:0]            outSrc1_o,
    output logic [`XLEN-1:0]            outSrc2_o,
    output logic [`REG_ADDR_W-1:0]      outRd_o,
    output logic                        outRegWe_o,
    output logic [2:0]                  outLoadCtl_o,
    output logic [2:0]                  outStoreCtl_o,
    output logic [`XLEN-1:0]            outStoreData_o,
    output logic                        outTaken_o,
    output logic [`XLEN-1:0]            outTarget_o
);

    hazInfo_t               haz;
    instrClass_e            decClass;
    aluOp_e                 decAluOp;
    logic [2:0]             decFunct3;
    logic [`REG_ADDR_W-1:0] decRd;
    logic [`XLEN-1:0]       decImm;

    srcPortIf srcs [`NUM_SRC] ();

    assign haz = '{
        exRd:      exRd_i,
        exRegWe:   exRegWe_i,
        memRd:     memRd_i,
        memRegWe:  memRegWe_i,
        memIsLoad: memIsLoad_i,
        memWbData: memWbData_i
    };

    instrDecoder uDecoder (
        .instr_i  (inInstr_i),
        .srcs     (srcs),
        .class_o  (decClass),
        .aluOp_o  (decAluOp),
        .funct3_o (decFunct3),
        .rd_o     (decRd),
        .imm_o    (decImm)
    );

    regFile uRegFile (
        .clk      (clk),
        .arstN_i  (arstN_i),
        .we_i     (wbWe_i),
        .wrAddr_i (wbRd_i),
        .wrData_i (wbData_i),
        .rd       (srcs)
    );

    // one operand unit per register source
    for (genvar gSrc = 0; gSrc < `NUM_SRC; gSrc++) begin : srcGen
        srcOperand uOperand (
            .src   (srcs[gSrc]),
            .haz_i (haz)
        );
    end

    issueStage uIssue (
        .clk            (clk),
        .arstN_i        (arstN_i),
        .inValid_i      (inValid_i),
        .inReady_o      (inReady_o),
        .pc_i           (inPc_i),
        .class_i        (decClass),
        .aluOp_i        (decAluOp),
        .funct3_i       (decFunct3),
        .rd_i           (decRd),
        .imm_i          (decImm),
        .srcs           (srcs),
        .outReady_i     (outReady_i),
        .outValid_o     (outValid_o),
        .outAluOp_o     (outAluOp_o),
        .outSrc1_o      (outSrc1_o),
        .outSrc2_o      (outSrc2_o),
        .outRd_o        (outRd_o),
        .outRegWe_o     (outRegWe_o),
        .outLoadCtl_o   (outLoadCtl_o),
        .outStoreCtl_o  (outStoreCtl_o),
        .outStoreData_o (outStoreData_o),
        .outTaken_o     (outTaken_o),
        .outTarget_o    (outTarget_o)
    );

endmodule

`default_nettype wire

// ==== tests/decodeModel.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    aluOp_e                 aluOp;
    logic [`XLEN-1:0]       src1;
    logic [`XLEN-1:0]       src2;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   regWe;
    logic [2:0]             loadCtl;
    logic [2:0]             storeCtl;
    logic [`XLEN-1:0]       storeData;
    logic                   taken;
    logic [`XLEN-1:0]       target;
} issueBundle_t;

logic [`XLEN-1:0] modelRegs [`NUM_REGS];

// value of a source as decode sees it in the current cycle
function automatic logic [`XLEN-1:0] readOperand(input logic [`REG_ADDR_W-1:0] a);
    if (a == '0) return '0;
    if (memRegWe_i && memRd_i == a && !memIsLoad_i) return memWbData_i; // MEM forward
    if (wbWe_i && wbRd_i == a) return wbData_i;                          // write-through
    return modelRegs[a];
endfunction

function automatic logic srcBlocked(input logic [`REG_ADDR_W-1:0] a);
    if (a == '0) return 1'b0;
    return (exRegWe_i && exRd_i == a) || (memRegWe_i && memRd_i == a && memIsLoad_i);
endfunction

function automatic logic predictStall(input logic [`XLEN-1:0] ins);
    if (ins[6:0] == `OP_BRANCH) return srcBlocked(ins[19:15]) || srcBlocked(ins[24:20]);
    if (ins[6:0] == `OP_JALR) return srcBlocked(ins[19:15]);
    return 1'b0;
endfunction

function automatic issueBundle_t expectBundle(input logic [`XLEN-1:0] ins,
                                              input logic [`XLEN-1:0] pc);
    issueBundle_t     b;
    logic [2:0]       f3;
    logic             alt;
    logic             writes;
    logic             tk;
    logic [`XLEN-1:0] immI, immS, immB, immJ, rs1, rs2;
    aluOp_e           arith;
    aluOp_e           arithTab [8];
    arithTab = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    f3 = ins[14:12];
    alt = ins[31:25] == `FUNCT7_ALT;
    immI = 32'($signed(ins[31:20]));
    immS = 32'($signed({ins[31:25], ins[11:7]}));
    immB = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
    immJ = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
    rs1 = readOperand(ins[19:15]);
    rs2 = readOperand(ins[24:20]);
    arith = arithTab[f3];
    if (alt && f3 == 3'd5) arith = ALU_SRA;
    if (alt && f3 == 3'd0 && ins[6:0] == `OP_R) arith = ALU_SUB; // no subi
    b = '0;
    b.loadCtl = `LS_NONE;
    b.storeCtl = `LS_NONE;
    writes = 1'b1;
    case (ins[6:0])
        `OP_R: begin
            b.aluOp = arith;
            b.src1 = rs1;
            b.src2 = rs2;
        end
        `OP_IMM: begin
            b.aluOp = arith;
            b.src1 = rs1;
            b.src2 = immI;
        end
        `OP_LOAD: begin
            b.aluOp = ALU_ADD;
            b.src1 = rs1;
            b.src2 = immI;
            b.loadCtl = f3;
        end
        `OP_STORE: begin
            b.aluOp = ALU_ADD;
            b.src1 = rs1;
            b.src2 = immS;
            b.storeCtl = f3;
            b.storeData = rs2;
            writes = 1'b0;
        end
        `OP_BRANCH: begin
            case (f3)
                3'd0: tk = rs1 == rs2;
                3'd1: tk = rs1 != rs2;
                3'd4: tk = $signed(rs1) < $signed(rs2);
                3'd5: tk = $signed(rs1) >= $signed(rs2);
                3'd6: tk = rs1 < rs2;
                3'd7: tk = rs1 >= rs2;
                default: tk = 1'b0;
            endcase
            b.taken = tk;
            b.target = tk ? pc + immB : '0;
            writes = 1'b0;
        end
        `OP_JAL, `OP_JALR: begin
            b.aluOp = ALU_ADD;
            b.src1 = pc;
            b.src2 = 32'd4;
            b.taken = 1'b1;
            b.target = (ins[6:0] == `OP_JAL) ? pc + immJ : (rs1 + immI) & ~32'd1;
        end
        default: writes = 1'b0;
    endcase
    if (writes) begin
        b.rd = ins[11:7];
        b.regWe = ins[11:7] != '0;
    end
    return b;
endfunction

// register write lands at the coming rising edge
task automatic commitWriteBack();
    if (wbWe_i && wbRd_i != '0) begin
        modelRegs[wbRd_i] = wbData_i;
    end
endtask

`endif

// ==== tests/decodeTop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decodeTop_tb import decodePkg::*; ;

    localparam int NUM_INSTR   = 2000;
    localparam int CYCLE_LIMIT = NUM_INSTR * 10; // ~2.5 cycles per instruction expected

    logic                   clk = 1'b0;
    logic                   arstN_i;
    logic                   inValid_i, inReady_o;
    logic [`XLEN-1:0]       inInstr_i, inPc_i;
    logic                   wbWe_i;
    logic [`REG_ADDR_W-1:0] wbRd_i;
    logic [`XLEN-1:0]       wbData_i;
    logic [`REG_ADDR_W-1:0] exRd_i, memRd_i;
    logic                   exRegWe_i, memRegWe_i, memIsLoad_i;
    logic [`XLEN-1:0]       memWbData_i;
    logic                   outValid_o, outReady_i;
    aluOp_e                 outAluOp_o;
    logic [`XLEN-1:0]       outSrc1_o, outSrc2_o, outStoreData_o, outTarget_o;
    logic [`REG_ADDR_W-1:0] outRd_o;
    logic                   outRegWe_o, outTaken_o;
    logic [2:0]             outLoadCtl_o, outStoreCtl_o;

    `include "decodeModel.svh"

    logic [31:0]  lfsr = 32'd11;
    issueBundle_t expQ [$];
    string        nameQ [$];
    int           valueErrs = 0;
    int           protoErrs = 0;
    int           checked = 0;
    int           sentCount = 0;
    int           cycles = 0;
    logic         pending = 1'b0;

    decodeTop i_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: only %0d of %0d instructions accepted after %0d cycles",
                     sentCount, NUM_INSTR, cycles);
            $display("errors: %0d value, %0d handshake, %0d bundles checked",
                     valueErrs, protoErrs, checked);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // random stimulus
    // ----------------------------------------------------------------------
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1; // galois step
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // half the time x0..x3 so hazards hit often
    function automatic logic [`REG_ADDR_W-1:0] regAddr();
        if (randBits(1) != 0) return 5'(randBits(2));
        return 5'(randBits(5));
    endfunction

    function automatic logic [31:0] makeInstr();
        logic [3:0]  sel;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        sel = 4'(randBits(4));
        rd = regAddr();
        rs1 = regAddr();
        rs2 = regAddr();
        f3 = 3'(randBits(3));
        imm = 12'(randBits(12));
        f7 = (randBits(1) != 0) ? `FUNCT7_ALT : 7'b0;
        case (sel)
            0, 1: return {(f3 == 3'd0 || f3 == 3'd5) ? f7 : 7'b0, rs2, rs1, f3, rd, `OP_R};
            2, 3: begin
                if (f3 == 3'd1) return {7'b0, imm[4:0], rs1, f3, rd, `OP_IMM};
                if (f3 == 3'd5) return {f7, imm[4:0], rs1, f3, rd, `OP_IMM};
                return {imm, rs1, f3, rd, `OP_IMM};
            end
            4, 5: return {imm, rs1, (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3, rd, `OP_LOAD};
            6, 7: return {imm[11:5], rs2, rs1, 1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0],
                          imm[4:0], `OP_STORE};
            8, 9, 10: return {imm[11:5], rs2, rs1,
                              (f3 == 3'd2 || f3 == 3'd3) ? {1'b1, f3[1:0]} : f3,
                              imm[4:0], `OP_BRANCH};
            11: return {imm, 8'(randBits(8)), rd, `OP_JAL};
            12, 13: return {imm, rs1, 3'b000, rd, `OP_JALR};
            default: return '0; // bubble word
        endcase
    endfunction

    function automatic string testName(input logic [31:0] ins);
        case (ins[6:0])
            `OP_R, `OP_IMM: return "arith";
            `OP_LOAD: return "load";
            `OP_STORE: return "store";
            `OP_BRANCH: return "branch";
            `OP_JAL, `OP_JALR: return "jump";
            default: return "nop";
        endcase
    endfunction

    task automatic driveInputs();
        if (!pending) begin // a held instruction stays put
            inValid_i = sentCount < NUM_INSTR && randBits(2) != 0;
            inInstr_i = makeInstr();
            inPc_i = {30'(randBits(30)), 2'b00};
        end
        outReady_i = randBits(2) != 0;
        wbWe_i = randBits(1) != 0;
        wbRd_i = regAddr();
        wbData_i = randBits(32);
        exRd_i = 5'(randBits(2));
        exRegWe_i = randBits(1) != 0;
        memRd_i = 5'(randBits(2));
        memRegWe_i = randBits(1) != 0;
        memIsLoad_i = randBits(1) != 0;
        memWbData_i = randBits(32);
    endtask

    // ----------------------------------------------------------------------
    // checking
    // ----------------------------------------------------------------------
    task automatic checkField(input string test, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            valueErrs++;
            $display("** Error %s %s: expected %h, actual %h", test, field, exp, act);
        end
    endtask

    task automatic compareBundle(input string t, input issueBundle_t e);
        checkField(t, "aluOp", 32'(e.aluOp), 32'(outAluOp_o));
        checkField(t, "src1", e.src1, outSrc1_o);
        checkField(t, "src2", e.src2, outSrc2_o);
        checkField(t, "rd", 32'(e.rd), 32'(outRd_o));
        checkField(t, "regWe", 32'(e.regWe), 32'(outRegWe_o));
        checkField(t, "loadCtl", 32'(e.loadCtl), 32'(outLoadCtl_o));
        checkField(t, "storeCtl", 32'(e.storeCtl), 32'(outStoreCtl_o));
        checkField(t, "storeData", e.storeData, outStoreData_o);
        checkField(t, "taken", 32'(e.taken), 32'(outTaken_o));
        checkField(t, "target", e.target, outTarget_o);
        checked++;
    endtask

    task automatic checkCycle();
        logic expReady;
        logic accepted;
        expReady = !(inValid_i && predictStall(inInstr_i)) && (!outValid_o || outReady_i);
        if (inReady_o !== expReady) begin
            protoErrs++;
            $display("** Error handshake inReady: expected %b, actual %b", expReady, inReady_o);
        end
        if (outValid_o && outReady_i) begin
            if (expQ.size() == 0) begin
                protoErrs++;
                $display("output transfer seen with no instruction outstanding");
            end else begin
                compareBundle(nameQ.pop_front(), expQ.pop_front());
            end
        end
        accepted = inValid_i && inReady_o;
        if (accepted) begin
            expQ.push_back(expectBundle(inInstr_i, inPc_i));
            nameQ.push_back(testName(inInstr_i));
            sentCount++;
        end
        pending = inValid_i && !accepted;
        commitWriteBack();
    endtask

    initial begin
        arstN_i = 1'b0;
        inValid_i = 1'b0;
        inInstr_i = '0;
        inPc_i = '0;
        outReady_i = 1'b0;
        wbWe_i = 1'b0;
        wbRd_i = '0;
        wbData_i = '0;
        exRd_i = '0;
        exRegWe_i = 1'b0;
        memRd_i = '0;
        memRegWe_i = 1'b0;
        memIsLoad_i = 1'b0;
        memWbData_i = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end

        repeat (4) begin
            @(negedge clk);
            if (outValid_o !== 1'b0) begin
                protoErrs++;
                $display("outValid_o is high during reset");
            end
        end
        arstN_i = 1'b1;
        #1;
        checkField("reset", "inReady", 32'd1, 32'(inReady_o));
        checkField("reset", "outValid", 32'd0, 32'(outValid_o));
        checkField("reset", "aluOp", 32'(ALU_NOP), 32'(outAluOp_o));
        checkField("reset", "src1", 32'd0, outSrc1_o);

        while (sentCount < NUM_INSTR || expQ.size() != 0) begin
            @(negedge clk);
            driveInputs();
            #1; // let the combinational ready settle
            checkCycle();
        end

        $display("errors: %0d value, %0d handshake, %0d bundles checked",
                 valueErrs, protoErrs, checked);
        if (valueErrs == 0 && protoErrs == 0 && checked == NUM_INSTR) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== decodeTop.f ====
+incdir+source
+incdir+tests
source/decodePkg.sv
source/srcPortIf.sv
source/instrDecoder.sv
source/regFile.sv
source/srcOperand.sv
source/issueStage.sv
source/decodeTop.sv
tests/decodeTop_tb.sv

// ==== Makefile ====
SRCS = decodeTop.f source/decode_defines.svh source/decodePkg.sv source/srcPortIf.sv \
       source/instrDecoder.sv source/regFile.sv source/srcOperand.sv \
       source/issueStage.sv source/decodeTop.sv tests/decodeModel.svh tests/decodeTop_tb.sv

.PHONY: run clean

obj_dir/VdecodeTop_tb: $(SRCS)
	verilator --binary --timing --top-module decodeTop_tb -f decodeTop.f -o VdecodeTop_tb

run: obj_dir/VdecodeTop_tb
	@out="$$(./obj_dir/VdecodeTop_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
